//--- filelist.f
verilog/dram_pkg.sv
verilog/dram_access_pkg.sv
verilog/address_mapper_if.sv
verilog/addr_mapper.sv
verilog/req_intake.sv
verilog/row_tracker.sv
verilog/dram_addr_front.sv
tests/dram_addr_front_tb.sv

//--- tests/dram_addr_front_tb.sv
//**********************************************************
// Directed testbench for the DDR4 address front end with
// reference model, compare tasks and cycle timeout
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module dram_addr_front_tb;
    import dram_pkg::*;
    import dram_access_pkg::*;

    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 10;
    // 1 + 102 + 5 + 3 + 3 + 600 transactions, 11 resets
    localparam int NUM_TRANS    = 714;
    localparam int NUM_RESETS   = 11;
    localparam int CYCLE_LIMIT  = 4 * (NUM_TRANS * 6 + RESET_CYCLES * NUM_RESETS);
    localparam int HS_LIMIT     = 20;

    logic          tb_CLK;
    logic          arst_n;
    logic          req;
    addr_t         address;
    device_cfg_e   device_cfg;
    logic          ack;
    rank_t         rank;
    bg_t           bg;
    bank_t         bank;
    row_t          row;
    col_t          col;
    offset_t       offset;
    access_class_e access_class;

    // Result captured when ack rises
    rank_t         got_rank;
    bg_t           got_bg;
    bank_t         got_bank;
    row_t          got_row;
    col_t          got_col;
    offset_t       got_offset;
    access_class_e got_class;

    // Reference model state and expectations
    logic          model_valid [32];
    row_t          model_row   [32];
    rank_t         exp_rank;
    bg_t           exp_bg;
    bank_t         exp_bank;
    row_t          exp_row;
    col_t          exp_col;
    offset_t       exp_offset;
    access_class_e exp_class;

    int mismatch_count;
    int timeout_count;
    int cycle_count;

    dram_addr_front u_dut (
        .tb_CLK       (tb_CLK),
        .arst_n       (arst_n),
        .req          (req),
        .address      (address),
        .device_cfg   (device_cfg),
        .ack          (ack),
        .rank         (rank),
        .bg           (bg),
        .bank         (bank),
        .row          (row),
        .col          (col),
        .offset       (offset),
        .access_class (access_class)
    );

    // 100 ns clock
    always #50 tb_CLK = ~tb_CLK;

    //**********************************************************
    // Compare tasks
    //**********************************************************
    task automatic check_fields(input string msg,
                                input rank_t e_rank, input bg_t e_bg, input bank_t e_bank,
                                input row_t e_row, input col_t e_col, input offset_t e_off,
                                input rank_t a_rank, input bg_t a_bg, input bank_t a_bank,
                                input row_t a_row, input col_t a_col, input offset_t a_off);
        string got_s;
        string exp_s;
        if ({e_rank, e_bg, e_bank, e_row, e_col, e_off} !==
            {a_rank, a_bg, a_bank, a_row, a_col, a_off}) begin
            mismatch_count++;
            got_s = $sformatf("rk%0h bg%0h bk%0h row%0h col%0h off%0h",
                              a_rank, a_bg, a_bank, a_row, a_col, a_off);
            exp_s = $sformatf("rk%0h bg%0h bk%0h row%0h col%0h off%0h",
                              e_rank, e_bg, e_bank, e_row, e_col, e_off);
            $display("MISMATCH @%0t: %s got %s, exp %s", $time, msg, got_s, exp_s);
        end
    endtask

    task automatic check_class(input string msg, input access_class_e expected,
                               input access_class_e actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH @%0t: %s class %s, expected %s",
                     $time, msg, actual.name(), expected.name());
        end
    endtask

    task automatic check_bit(input string msg, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH @%0t: %s is %b, expected %b", $time, msg, actual, expected);
        end
    endtask

    //**********************************************************
    // Reference model
    //**********************************************************
    // Mapping table, then classification against the model table
    task automatic model_access(input addr_t a, input device_cfg_e cfg);
        logic ign;
        int   idx;
        exp_offset = a[2:0];
        exp_col    = a[12:3];
        exp_bank   = a[14:13];
        case (cfg)
            CFG_X8: begin
                exp_bg   = a[16:15];
                exp_row  = {1'b0, a[31:17]};
                exp_rank = a[32];
                ign      = a[33];
            end
            CFG_X16: begin
                exp_bg   = {1'b0, a[15]};
                exp_row  = {1'b0, a[30:16]};
                exp_rank = a[31];
                ign      = a[33] | a[32];
            end
            default: begin
                exp_bg   = a[16:15];
                exp_row  = a[32:17];
                exp_rank = a[33];
                ign      = 1'b0;
            end
        endcase
        idx = exp_rank * 16 + exp_bg * 4 + exp_bank;
        if (ign) begin
            exp_class = ACC_OUT_OF_RANGE;
        end else if (!model_valid[idx]) begin
            exp_class        = ACC_EMPTY;
            model_valid[idx] = 1'b1;
            model_row[idx]   = exp_row;
        end else if (model_row[idx] == exp_row) begin
            exp_class = ACC_HIT;
        end else begin
            exp_class      = ACC_CONFLICT;
            model_row[idx] = exp_row;
        end
    endtask

    //**********************************************************
    // Stimulus helpers
    //**********************************************************
    task automatic next_cycle();
        @(posedge tb_CLK);
        #DRIVE_DELAY;
    endtask

    // Reset pulse that also clears the model table
    task automatic apply_reset();
        int i;
        arst_n = 1'b0;
        req    = 1'b0;
        for (i = 0; i < RESET_CYCLES; i++) begin
            next_cycle();
            check_bit("ack during reset", 1'b0, ack);
        end
        arst_n = 1'b1;
        for (i = 0; i < 32; i++) begin
            model_valid[i] = 1'b0;
            model_row[i]   = '0;
        end
        next_cycle();
        check_bit("ack after reset", 1'b0, ack);
        check_fields("result after reset", '0, '0, '0, '0, '0, '0,
                     rank, bg, bank, row, col, offset);
        check_class("result after reset", ACC_HIT, access_class);
    endtask

    // One full four-phase transaction with req held for hold extra cycles
    task automatic do_access(input addr_t a, input device_cfg_e cfg, input int hold);
        int edges;
        int i;
        next_cycle();
        req        = 1'b1;
        address    = a;
        device_cfg = cfg;
        edges      = 0;
        // Wait for ack
        while (!ack && edges < HS_LIMIT) begin
            next_cycle();
            edges++;
        end
        if (!ack) begin
            timeout_count++;
            $display("Handshake timeout at %0t: ack never rose for address %h", $time, a);
        end
        check_bit("ack two edges after req", 1'b1, edges == 2);
        got_rank   = rank;
        got_bg     = bg;
        got_bank   = bank;
        got_row    = row;
        got_col    = col;
        got_offset = offset;
        got_class  = access_class;
        // Result must hold under back-pressure
        for (i = 0; i < hold; i++) begin
            next_cycle();
            check_bit("ack while req held", 1'b1, ack);
            check_fields("held result", got_rank, got_bg, got_bank, got_row, got_col,
                         got_offset, rank, bg, bank, row, col, offset);
            check_class("held result", got_class, access_class);
        end
        req   = 1'b0;
        edges = 0;
        while ((ack || edges == 0) && edges < HS_LIMIT) begin
            next_cycle();
            edges++;
        end
        if (ack) begin
            timeout_count++;
            $display("Handshake timeout at %0t: ack stayed high after req dropped", $time);
        end
        check_bit("ack falls one edge after req drop", 1'b1, edges == 1);
        // RELEASE cycle before the next request
        next_cycle();
    endtask

    // Transaction checked against the reference model
    task automatic run_access(input addr_t a, input device_cfg_e cfg, input int hold);
        do_access(a, cfg, hold);
        model_access(a, cfg);
        check_fields("decode", exp_rank, exp_bg, exp_bank, exp_row, exp_col, exp_offset,
                     got_rank, got_bg, got_bank, got_row, got_col, got_offset);
        check_class("model class", exp_class, got_class);
    endtask

    //**********************************************************
    // Tests
    //**********************************************************
    task automatic test_handshake();
        run_access({1'b1, 16'h00a5, 2'd2, 2'd1, 10'h155, 3'd6}, CFG_X4, 5);
        check_bit("ack idle after transaction", 1'b0, ack);
    endtask

    // Walking one over every address bit
    task automatic test_decode(input device_cfg_e cfg);
        int b;
        apply_reset();
        for (b = 0; b < ADDR_W; b++) begin
            run_access(addr_t'(1) << b, cfg, 0);
        end
    endtask

    task automatic test_classes();
        apply_reset();
        run_access({1'b0, 16'h0123, 2'd1, 2'd2, 10'h005, 3'd0}, CFG_X4, 0);
        check_class("row A first", ACC_EMPTY, got_class);
        run_access({1'b0, 16'h0123, 2'd1, 2'd2, 10'h006, 3'd1}, CFG_X4, 0);
        check_class("row A again", ACC_HIT, got_class);
        run_access({1'b0, 16'h0456, 2'd1, 2'd2, 10'h005, 3'd0}, CFG_X4, 0);
        check_class("row B", ACC_CONFLICT, got_class);
        run_access({1'b0, 16'h0123, 2'd1, 2'd2, 10'h005, 3'd0}, CFG_X4, 0);
        check_class("row A after B", ACC_CONFLICT, got_class);
        // Other bank, same row
        run_access({1'b0, 16'h0123, 2'd1, 2'd3, 10'h005, 3'd0}, CFG_X4, 0);
        check_class("other bank", ACC_EMPTY, got_class);
    endtask

    // x16 layout is {ignored, rank, row, bg, bank, col, offset}
    task automatic test_out_of_range();
        apply_reset();
        run_access({2'b10, 1'b0, 15'h0123, 1'b1, 2'd1, 10'h010, 3'd0}, CFG_X16, 0);
        check_class("bit 33 set", ACC_OUT_OF_RANGE, got_class);
        run_access({2'b01, 1'b0, 15'h0123, 1'b1, 2'd1, 10'h010, 3'd0}, CFG_X16, 0);
        check_class("bit 32 set", ACC_OUT_OF_RANGE, got_class);
        run_access({2'b00, 1'b0, 15'h0123, 1'b1, 2'd1, 10'h010, 3'd0}, CFG_X16, 0);
        check_class("in range after", ACC_EMPTY, got_class);
    endtask

    task automatic test_reset_clears();
        apply_reset();
        run_access({1'b1, 16'h7777, 2'd3, 2'd0, 10'h001, 3'd0}, CFG_X4, 0);
        run_access({1'b1, 16'h7777, 2'd3, 2'd0, 10'h001, 3'd0}, CFG_X4, 0);
        check_class("hit before reset", ACC_HIT, got_class);
        apply_reset();
        run_access({1'b1, 16'h7777, 2'd3, 2'd0, 10'h001, 3'd0}, CFG_X4, 0);
        check_class("after reset", ACC_EMPTY, got_class);
    endtask

    // Rows from a set of four so hits and conflicts occur
    task automatic test_random(input device_cfg_e cfg);
        addr_t a;
        row_t  row_val;
        int    i;
        apply_reset();
        for (i = 0; i < 200; i++) begin
            a       = addr_t'({$urandom(), $urandom()});
            row_val = row_t'(($urandom() % 4) * 16'h1357);
            case (cfg)
                CFG_X4:  a[32:17] = row_val;
                CFG_X8:  a[31:17] = row_val[14:0];
                default: a[30:16] = row_val[14:0];
            endcase
            // Mostly in range, some out of range
            if (($urandom() % 8) != 0) begin
                if (cfg == CFG_X8) begin
                    a[33] = 1'b0;
                end else if (cfg == CFG_X16) begin
                    a[33:32] = 2'b00;
                end
            end
            run_access(a, cfg, 0);
        end
    endtask

    //**********************************************************
    // Run control
    //**********************************************************
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge tb_CLK);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        tb_CLK         = 1'b0;
        arst_n         = 1'b0;
        req            = 1'b0;
        address        = '0;
        device_cfg     = CFG_X4;
        mismatch_count = 0;
        timeout_count  = 0;
        void'($urandom(32'h2d61));

        apply_reset();
        test_handshake();
        test_decode(CFG_X4);
        test_decode(CFG_X8);
        test_decode(CFG_X16);
        test_classes();
        test_out_of_range();
        test_reset_clears();
        test_random(CFG_X4);
        test_random(CFG_X8);
        test_random(CFG_X16);

        $display("Done after %0d cycles: %0d mismatches, %0d handshake timeouts",
                 cycle_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/addr_mapper.sv
//**********************************************************
// Combinational address decode for x4, x8 and x16 parts
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module addr_mapper (
    address_mapper_if.mapper amif
);
    import dram_pkg::*;

    //******************************************************
    // Fields common to all organizations
    //******************************************************
    // Byte within the beat
    assign amif.offset = amif.address[OFFSET_W-1:0];
    // Column sits right above the offset
    assign amif.col    = amif.address[COL_LSB +: COL_W];
    // Bank within group
    assign amif.bank   = amif.address[BANK_LSB +: BANK_W];

    //******************************************************
    // Organization-dependent fields
    //******************************************************
    // Narrower parts pull rank and row down by one or two bits,
    // leaving the top of the address unused
    always_comb begin
        unique case (amif.configs)
            CFG_X8: begin
                // Full bank group, 15-bit row
                amif.bg     = amif.address[BG_LSB +: BG_W];
                amif.row    = row_t'(amif.address[31:17]);
                amif.rank   = amif.address[32];
                // Only bit 33 left over
                amif.ignore = amif.address[33];
            end
            CFG_X16: begin
                // Single bank group bit with the upper bit forced low
                amif.bg     = bg_t'(amif.address[BG_LSB]);
                // Row shifts down into the freed bit
                amif.row    = row_t'(amif.address[30:16]);
                amif.rank   = amif.address[31];
                // Two bits above rank
                amif.ignore = |amif.address[33:32];
            end
            default: begin
                // x4 layout uses every address bit
                amif.bg     = amif.address[BG_LSB +: BG_W];
                amif.row    = amif.address[32:17];
                amif.rank   = amif.address[33];
                amif.ignore = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/address_mapper_if.sv
//**********************************************************
// Address mapper interface: address, organization, fields
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

interface address_mapper_if;
    import dram_pkg::*;

    // Captured request
    addr_t       address;
    device_cfg_e configs;

    // Decoded fields
    rank_t       rank;
    bg_t         bg;
    bank_t       bank;
    row_t        row;
    col_t        col;
    offset_t     offset;
    // Unused high bits were set
    logic        ignore;

    // Handshake front end
    modport source (output address, configs);

    // Combinational decoder
    modport mapper (
        input  address, configs,
        output rank, bg, bank, row, col, offset, ignore
    );

    // Open-row tracker
    modport sink (input rank, bg, bank, row, col, offset, ignore);

endinterface

`default_nettype wire

//--- verilog/dram_access_pkg.sv
//**********************************************************
// Access classes, open-row table index and intake FSM states
//**********************************************************
`default_nettype none

package dram_access_pkg;

    // 2 ranks x 4 bank groups x 4 banks
    localparam int NUM_BANKS  = 32;
    localparam int BANK_IDX_W = $clog2(NUM_BANKS);

    typedef logic [BANK_IDX_W-1:0] bank_idx_t;

    // Result of one lookup against the open-row table
    typedef enum logic [1:0] {
        ACC_HIT,
        ACC_EMPTY,
        ACC_CONFLICT,
        ACC_OUT_OF_RANGE
    } access_class_e;

    // Four-phase handshake sequence
    typedef enum logic [1:0] {IDLE, LOOKUP, ACK, RELEASE} intake_state_e;

    // Flat table index with rank in the top bit
    function automatic bank_idx_t bank_index(input dram_pkg::rank_t rank,
                                             input dram_pkg::bg_t   bg,
                                             input dram_pkg::bank_t bank);
        return {rank, bg, bank};
    endfunction

endpackage

`default_nettype wire

//--- verilog/dram_addr_front.sv
//**********************************************************
// DDR4 address front end top: intake, mapper and tracker
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module dram_addr_front (
    input  logic                           tb_CLK,
    input  logic                           arst_n,
    // Four-phase request side
    input  logic                           req,
    input  dram_pkg::addr_t                address,
    input  dram_pkg::device_cfg_e          device_cfg,
    output logic                           ack,
    // Result, valid while ack is high
    output dram_pkg::rank_t                rank,
    output dram_pkg::bg_t                  bg,
    output dram_pkg::bank_t                bank,
    output dram_pkg::row_t                 row,
    output dram_pkg::col_t                 col,
    output dram_pkg::offset_t              offset,
    output dram_access_pkg::access_class_e access_class
);

    //******************************************************
    // Internal connections
    //******************************************************
    // Captured address in, decoded fields out
    address_mapper_if amif ();

    // One-cycle strobe from intake to tracker
    logic lookup;

    //******************************************************
    // Instances
    //******************************************************
    // Handshake and capture
    req_intake u_intake (
        .tb_CLK     (tb_CLK),
        .arst_n     (arst_n),
        .req        (req),
        .address    (address),
        .device_cfg (device_cfg),
        .ack        (ack),
        .lookup     (lookup),
        .amif       (amif)
    );

    // Zero-latency field decode
    addr_mapper u_mapper (
        .amif (amif)
    );

    // Open-row table and result
    row_tracker u_tracker (
        .tb_CLK       (tb_CLK),
        .arst_n       (arst_n),
        .lookup       (lookup),
        .amif         (amif),
        .rank         (rank),
        .bg           (bg),
        .bank         (bank),
        .row          (row),
        .col          (col),
        .offset       (offset),
        .access_class (access_class)
    );

endmodule

`default_nettype wire

//--- verilog/dram_pkg.sv
//**********************************************************
// DRAM geometry: address and field widths, field positions
// and device organization encoding
//**********************************************************
`default_nettype none

package dram_pkg;

    //******************************************************
    // Widths
    //******************************************************
    // Physical byte address
    localparam int ADDR_W   = 34;
    // Byte within an 8-byte beat
    localparam int OFFSET_W = 3;
    localparam int COL_W    = 10;
    localparam int BANK_W   = 2;
    // Full bank group width as used by x4 and x8
    localparam int BG_W     = 2;
    // Widest row, which is the x4 layout
    localparam int ROW_W    = 16;
    localparam int RANK_W   = 1;

    // Fields at the same place in every organization
    localparam int COL_LSB  = 3;
    localparam int BANK_LSB = 13;
    localparam int BG_LSB   = 15;

    //******************************************************
    // Types
    //******************************************************
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [COL_W-1:0]    col_t;
    typedef logic [BANK_W-1:0]   bank_t;
    typedef logic [BG_W-1:0]     bg_t;
    typedef logic [ROW_W-1:0]    row_t;
    typedef logic [RANK_W-1:0]   rank_t;

    // Device organization that holds from reset onward
    typedef enum logic [1:0] {CFG_X4, CFG_X8, CFG_X16} device_cfg_e;

endpackage

`default_nettype wire

//--- verilog/req_intake.sv
//**********************************************************
// Four-phase req/ack front end and lookup sequencing
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module req_intake (
    input  logic                  tb_CLK,
    input  logic                  arst_n,
    input  logic                  req,
    input  dram_pkg::addr_t       address,
    input  dram_pkg::device_cfg_e device_cfg,
    output logic                  ack,
    output logic                  lookup,
    address_mapper_if.source      amif
);
    import dram_access_pkg::*;

    intake_state_e state;
    intake_state_e state_next;
    logic          accept;

    // New request seen while idle
    assign accept = req && (state == IDLE);

    //******************************************************
    // Handshake FSM
    //******************************************************
    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (req) begin
                    state_next = LOOKUP;
                end
            end
            // One cycle for the table lookup
            LOOKUP:  state_next = ACK;
            ACK: begin
                // Hold ack as long as req is held
                if (!req) begin
                    state_next = RELEASE;
                end
            end
            RELEASE: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge tb_CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request payload held for the whole transaction
    always_ff @(posedge tb_CLK) begin
        if (accept) begin
            amif.address <= address;
            amif.configs <= device_cfg;
        end
    end

    // Strobe and ack straight from the state
    assign lookup = (state == LOOKUP);
    assign ack    = (state == ACK);

endmodule

`default_nettype wire

//--- verilog/row_tracker.sv
//**********************************************************
// Open-row table per bank, access classification and
// registered decode result
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module row_tracker (
    input  logic                           tb_CLK,
    input  logic                           arst_n,
    input  logic                           lookup,
    address_mapper_if.sink                 amif,
    output dram_pkg::rank_t                rank,
    output dram_pkg::bg_t                  bg,
    output dram_pkg::bank_t                bank,
    output dram_pkg::row_t                 row,
    output dram_pkg::col_t                 col,
    output dram_pkg::offset_t              offset,
    output dram_access_pkg::access_class_e access_class
);
    import dram_pkg::*;
    import dram_access_pkg::*;

    //******************************************************
    // Table storage
    //******************************************************
    // Entry holds a live row
    logic [NUM_BANKS-1:0] row_valid;
    // Last row opened in each bank
    row_t                 open_row [NUM_BANKS];

    bank_idx_t     idx;
    row_t          stored_row;
    access_class_e class_next;
    logic          table_write;

    // Flat bank index from the decoded fields
    assign idx        = bank_index(amif.rank, amif.bg, amif.bank);
    assign stored_row = open_row[idx];

    //******************************************************
    // Classification
    //******************************************************
    always_comb begin
        if (amif.ignore) begin
            // Unused address bits set, table left alone
            class_next = ACC_OUT_OF_RANGE;
        end else if (!row_valid[idx]) begin
            class_next = ACC_EMPTY;
        end else if (stored_row == amif.row) begin
            class_next = ACC_HIT;
        end else begin
            class_next = ACC_CONFLICT;
        end
    end

    // Empty and conflict both (re)open the bank with the new row
    assign table_write = lookup &&
                         ((class_next == ACC_EMPTY) || (class_next == ACC_CONFLICT));

    //******************************************************
    // Table update
    //******************************************************
    always_ff @(posedge tb_CLK or negedge arst_n) begin
        if (!arst_n) begin
            row_valid <= '0;
        end else if (table_write) begin
            row_valid[idx] <= 1'b1;
        end
    end

    // New open row of the addressed bank
    always_ff @(posedge tb_CLK) begin
        if (table_write) begin
            open_row[idx] <= amif.row;
        end
    end

    //******************************************************
    // Result registers
    //******************************************************
    // Loaded once per lookup, then held through the handshake
    always_ff @(posedge tb_CLK or negedge arst_n) begin
        if (!arst_n) begin
            rank         <= '0;
            bg           <= '0;
            bank         <= '0;
            row          <= '0;
            col          <= '0;
            offset       <= '0;
            // Encodes as zero
            access_class <= ACC_HIT;
        end else if (lookup) begin
            rank         <= amif.rank;
            bg           <= amif.bg;
            bank         <= amif.bank;
            row          <= amif.row;
            col          <= amif.col;
            offset       <= amif.offset;
            access_class <= class_next;
        end
    end

endmodule

`default_nettype wire
